/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = enet_irq_tb
FILELIST = enet_irq.f
OBJ_DIR  = obj_dir

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

# build, run, and fail unless the pass line shows up
sim:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf $(OBJ_DIR)

/* enet_irq.f */
logic/enet_irq_pkg.sv
logic/enet_irq_csr.sv
logic/enet_intr_coalesce.sv
logic/enet_irq_combine.sv
logic/enet_irq_top.sv
sim/enet_irq_tb.sv

/* logic/enet_intr_coalesce.sv */
`timescale 1ns/1ps

module enet_intr_coalesce (
    input  logic                              clk,
    input  logic                              rst_n,

    input  logic                              intr_in,
    input  logic                              coal_wen,
    input  logic [enet_irq_pkg::data_w-1:0]   wdata,
    input  logic                              eir_clr,

    output logic [enet_irq_pkg::data_w-1:0]   coal,
    output logic                              intr
);

    typedef enum logic {
        st_idle,
        st_wait
    } coal_state_t;

    coal_state_t                             state;

    logic                                    en;
    logic [enet_irq_pkg::coal_ft_w-1:0]      ft;
    logic [enet_irq_pkg::coal_tt_w-1:0]      tt;

    logic [enet_irq_pkg::coal_ft_w-1:0]      ft_cnt;
    logic [enet_irq_pkg::tmr_cnt_w-1:0]      tmr_cnt;
    logic [enet_irq_pkg::tmr_cnt_w-1:0]      tmr_lim;

    logic                                    ft_hit;
    logic                                    tt_hit;
    logic                                    coal_hit;
    logic                                    intr_set;

    // coalescing register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            en <= 1'b0;
            ft <= '0;
            tt <= '0;
        end else if (coal_wen) begin
            en <= wdata[enet_irq_pkg::coal_en_bit];
            ft <= wdata[enet_irq_pkg::coal_ft_lsb +: enet_irq_pkg::coal_ft_w];
            tt <= wdata[enet_irq_pkg::coal_tt_lsb +: enet_irq_pkg::coal_tt_w];
        end
    end

    always_comb begin
        coal = '0;
        coal[enet_irq_pkg::coal_en_bit] = en;
        coal[enet_irq_pkg::coal_ft_lsb +: enet_irq_pkg::coal_ft_w] = ft;
        coal[enet_irq_pkg::coal_tt_lsb +: enet_irq_pkg::coal_tt_w] = tt;
    end

    assign tmr_lim = {tt, {enet_irq_pkg::coal_tt_shift{1'b0}}}; // tt * 32

    // a zero threshold never matches by itself
    assign ft_hit   = (ft != '0) && (ft_cnt == ft);
    assign tt_hit   = (tt != '0) && (tmr_cnt == tmr_lim);
    assign coal_hit = (state == st_wait) && (ft_hit || tt_hit);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (en && intr_in) begin
                        state <= st_wait;
                    end
                end
                st_wait: begin
                    if (coal_hit || !en) begin
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // frame and timer counters, loaded with 1 by the first frame
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ft_cnt  <= '0;
            tmr_cnt <= '0;
        end else if (state == st_idle) begin
            if (en && intr_in) begin
                ft_cnt  <= 1;
                tmr_cnt <= 1;
            end
        end else begin
            tmr_cnt <= tmr_cnt + 1'b1;
            if (intr_in) begin
                ft_cnt <= ft_cnt + 1'b1;
            end
        end
    end

    assign intr_set = en ? coal_hit : intr_in; // direct mode when disabled

    // EIR bit, set wins over clear
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            intr <= 1'b0;
        end else if (intr_set) begin
            intr <= 1'b1;
        end else if (eir_clr) begin
            intr <= 1'b0;
        end
    end

    a_ft_bound: assert property (@(posedge clk) disable iff (!rst_n)
        (state == st_wait) && (ft != '0) |-> (ft_cnt <= ft));

endmodule

/* logic/enet_irq_combine.sv */
`timescale 1ns/1ps

module enet_irq_combine (
    input  logic                              clk,
    input  logic                              rst_n,

    input  logic                              rx_intr,
    input  logic                              tx_intr,
    input  logic                              eir_wen,
    input  logic                              eimr_wen,
    input  logic [enet_irq_pkg::data_w-1:0]   wdata,

    output logic                              rx_clr,
    output logic                              tx_clr,
    output logic [enet_irq_pkg::eir_w-1:0]    eir,
    output logic [enet_irq_pkg::eir_w-1:0]    eimr,
    output logic                              irq
);

    logic [enet_irq_pkg::eir_w-1:0] eir_pend;

    always_comb begin
        eir = '0;
        eir[enet_irq_pkg::eir_rxf_bit] = rx_intr;
        eir[enet_irq_pkg::eir_txf_bit] = tx_intr;
    end

    // mask register, 1 enables the cause
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            eimr <= '0;
        end else if (eimr_wen) begin
            eimr[enet_irq_pkg::eir_rxf_bit] <= wdata[enet_irq_pkg::eir_rxf_bit];
            eimr[enet_irq_pkg::eir_txf_bit] <= wdata[enet_irq_pkg::eir_txf_bit];
        end
    end

    // write-one-to-clear, registered so the bit drops two edges after the write
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_clr <= 1'b0;
            tx_clr <= 1'b0;
        end else begin
            rx_clr <= eir_wen && wdata[enet_irq_pkg::eir_rxf_bit];
            tx_clr <= eir_wen && wdata[enet_irq_pkg::eir_txf_bit];
        end
    end

    assign eir_pend = eir & eimr;
    assign irq      = |eir_pend; // level line to the cpu

    // the level holds until a cause is cleared or masked
    a_irq_hold: assert property (@(posedge clk) disable iff (!rst_n)
        irq && !rx_clr && !tx_clr && !eimr_wen |=> irq);

endmodule

/* logic/enet_irq_csr.sv */
`timescale 1ns/1ps

module enet_irq_csr (
    input  logic                              clk,
    input  logic                              rst_n,

    input  logic                              req,
    input  logic                              we,
    input  logic [enet_irq_pkg::addr_w-1:0]   addr,
    input  logic [enet_irq_pkg::data_w-1:0]   wdata,
    output logic                              ack,
    output logic [enet_irq_pkg::data_w-1:0]   rdata,

    output logic                              rx_coal_wen,
    output logic                              tx_coal_wen,
    output logic                              eir_wen,
    output logic                              eimr_wen,

    input  logic [enet_irq_pkg::data_w-1:0]   rx_coal,
    input  logic [enet_irq_pkg::data_w-1:0]   tx_coal,
    input  logic [enet_irq_pkg::eir_w-1:0]    eir,
    input  logic [enet_irq_pkg::eir_w-1:0]    eimr
);

    typedef enum logic {
        st_idle,
        st_hold
    } csr_state_t;

    csr_state_t                          state;
    logic                                accept;
    logic [enet_irq_pkg::data_w-1:0]     rd_mux;

    assign accept = (state == st_idle) && req && !ack;

    always_comb begin
        case (addr)
            enet_irq_pkg::addr_eir: begin
                rd_mux = {{(enet_irq_pkg::data_w-enet_irq_pkg::eir_w){1'b0}}, eir};
            end
            enet_irq_pkg::addr_eimr: begin
                rd_mux = {{(enet_irq_pkg::data_w-enet_irq_pkg::eir_w){1'b0}}, eimr};
            end
            enet_irq_pkg::addr_rx_coal: begin
                rd_mux = rx_coal & enet_irq_pkg::coal_mask;
            end
            enet_irq_pkg::addr_tx_coal: begin
                rd_mux = tx_coal & enet_irq_pkg::coal_mask;
            end
            default: begin
                rd_mux = '0; // unused addresses read zero
            end
        endcase
    end

    // four-phase acceptor: idle -> hold (ack up, wait for req low) -> idle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
            ack   <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (accept) begin
                        state <= st_hold;
                    end
                end
                st_hold: begin
                    if (!ack) begin
                        ack <= 1'b1; // same edge the write lands
                    end else if (!req) begin
                        ack   <= 1'b0;
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                    ack   <= 1'b0;
                end
            endcase
        end
    end

    // strobes are one cycle wide, issued from the accept edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_coal_wen <= 1'b0;
            tx_coal_wen <= 1'b0;
            eir_wen     <= 1'b0;
            eimr_wen    <= 1'b0;
        end else begin
            rx_coal_wen <= accept && we && (addr == enet_irq_pkg::addr_rx_coal);
            tx_coal_wen <= accept && we && (addr == enet_irq_pkg::addr_tx_coal);
            eir_wen     <= accept && we && (addr == enet_irq_pkg::addr_eir);
            eimr_wen    <= accept && we && (addr == enet_irq_pkg::addr_eimr);
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rdata <= rd_mux; // held until the next access
        end
    end

    // ack only comes up for a request held across the accept and ack edges
    a_ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ack) |-> $past(req) && $past(req, 2));

    a_wen_single: assert property (@(posedge clk) disable iff (!rst_n)
        (rx_coal_wen || tx_coal_wen || eir_wen || eimr_wen)
        |=> !(rx_coal_wen || tx_coal_wen || eir_wen || eimr_wen));

endmodule

/* logic/enet_irq_pkg.sv */
package enet_irq_pkg;

    // host port
    localparam int addr_w = 4;
    localparam int data_w = 32;

    localparam logic [addr_w-1:0] addr_eir     = 4'd0;
    localparam logic [addr_w-1:0] addr_eimr    = 4'd1;
    localparam logic [addr_w-1:0] addr_rx_coal = 4'd2;
    localparam logic [addr_w-1:0] addr_tx_coal = 4'd3;

    // coalescing register layout
    localparam int coal_en_bit = 31;
    localparam int coal_ft_lsb = 20; // frame threshold, bits 27:20
    localparam int coal_ft_w   = 8;
    localparam int coal_tt_lsb = 0;  // timer threshold, bits 15:0
    localparam int coal_tt_w   = 16;

    // one timer threshold unit is 32 clocks
    localparam int coal_tt_shift = 5;
    localparam int tmr_cnt_w     = coal_tt_w + coal_tt_shift; // 21

    // only enable, frame and timer fields are writable
    localparam logic [data_w-1:0] coal_mask = 32'h8ff0_ffff;

    // EIR and EIMR share the same bit layout
    localparam int eir_w       = 2;
    localparam int eir_rxf_bit = 1;
    localparam int eir_txf_bit = 0;

endpackage

/* logic/enet_irq_top.sv */
`timescale 1ns/1ps

module enet_irq_top (
    input  logic                              clk,
    input  logic                              rst_n,

    input  logic                              req,
    input  logic                              we,
    input  logic [enet_irq_pkg::addr_w-1:0]   addr,
    input  logic [enet_irq_pkg::data_w-1:0]   wdata,
    output logic                              ack,
    output logic [enet_irq_pkg::data_w-1:0]   rdata,

    input  logic                              rx_frame,
    input  logic                              tx_frame,

    output logic                              irq
);

    logic                              rx_coal_wen;
    logic                              tx_coal_wen;
    logic                              eir_wen;
    logic                              eimr_wen;
    logic [enet_irq_pkg::data_w-1:0]   rx_coal;
    logic [enet_irq_pkg::data_w-1:0]   tx_coal;
    logic [enet_irq_pkg::eir_w-1:0]    eir;
    logic [enet_irq_pkg::eir_w-1:0]    eimr;
    logic                              rx_intr;
    logic                              tx_intr;
    logic                              rx_clr;
    logic                              tx_clr;

    enet_irq_csr csr_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (req),
        .we          (we),
        .addr        (addr),
        .wdata       (wdata),
        .ack         (ack),
        .rdata       (rdata),
        .rx_coal_wen (rx_coal_wen),
        .tx_coal_wen (tx_coal_wen),
        .eir_wen     (eir_wen),
        .eimr_wen    (eimr_wen),
        .rx_coal     (rx_coal),
        .tx_coal     (tx_coal),
        .eir         (eir),
        .eimr        (eimr)
    );

    enet_intr_coalesce rx_coal_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .intr_in  (rx_frame),
        .coal_wen (rx_coal_wen),
        .wdata    (wdata),
        .eir_clr  (rx_clr),
        .coal     (rx_coal),
        .intr     (rx_intr)
    );

    enet_intr_coalesce tx_coal_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .intr_in  (tx_frame),
        .coal_wen (tx_coal_wen),
        .wdata    (wdata),
        .eir_clr  (tx_clr),
        .coal     (tx_coal),
        .intr     (tx_intr)
    );

    enet_irq_combine combine_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .rx_intr  (rx_intr),
        .tx_intr  (tx_intr),
        .eir_wen  (eir_wen),
        .eimr_wen (eimr_wen),
        .wdata    (wdata),
        .rx_clr   (rx_clr),
        .tx_clr   (tx_clr),
        .eir      (eir),
        .eimr     (eimr),
        .irq      (irq)
    );

endmodule

/* sim/enet_irq_tb.sv */
`timescale 1ns/1ps

module enet_irq_tb;

    typedef enum {op_write, op_read, op_burst, op_wait} op_t;

    // for a read, data is the expected read data
    typedef struct {
        op_t                             op;
        logic [enet_irq_pkg::addr_w-1:0] addr;
        logic [31:0]                     data;
        int                              rx_n;
        int                              tx_n;
        int                              len;
        logic [31:0]                     exp_eir;
        logic [31:0]                     exp_irq;
    } step_t;

    localparam int ack_limit = 16;

    logic                            clk = 1'b0;
    logic                            rst_n;
    logic                            req;
    logic                            we;
    logic [enet_irq_pkg::addr_w-1:0] addr;
    logic [enet_irq_pkg::data_w-1:0] wdata;
    logic                            ack;
    logic [enet_irq_pkg::data_w-1:0] rdata;
    logic                            rx_frame;
    logic                            tx_frame;
    logic                            irq;

    step_t steps[$];
    int    errors   = 0;
    int    cur_step = 0;

    enet_irq_top enet_irq_top_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .we       (we),
        .addr     (addr),
        .wdata    (wdata),
        .ack      (ack),
        .rdata    (rdata),
        .rx_frame (rx_frame),
        .tx_frame (tx_frame),
        .irq      (irq)
    );

    always #5 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        assert (got === exp) else begin
            errors++;
            $display("Error %s expected 0x%h got 0x%h at step %0d", name, exp, got, cur_step);
        end
    endtask

    // four-phase access, returns at a falling edge with ack low
    task automatic bus_access(input logic wr, input logic [enet_irq_pkg::addr_w-1:0] a,
                              input logic [31:0] d, output logic [31:0] rd);
        int cycles;
        @(posedge clk);
        req   <= 1'b1;
        we    <= wr;
        addr  <= a;
        wdata <= d;
        cycles = 0;
        @(negedge clk);
        while (!ack && cycles < ack_limit) begin
            @(negedge clk);
            cycles++;
        end
        assert (ack) else begin
            errors++;
            $display("handshake failed at step %0d: no ack for address 0x%h", cur_step, a);
        end
        if (ack) begin
            check_value("ack_latency", 32'd2, cycles);
        end
        rd = rdata;
        @(posedge clk);
        req <= 1'b0;
        cycles = 0;
        @(negedge clk);
        while (ack && cycles < ack_limit) begin
            @(negedge clk);
            cycles++;
        end
        assert (!ack) else begin
            errors++;
            $display("handshake failed at step %0d: ack stayed high after req dropped", cur_step);
        end
        if (!ack) begin
            check_value("ack_release", 32'd1, cycles);
        end
    endtask

    // one-cycle pulses, random gaps between them, none after the last
    task automatic send_frames(input int rx_n, input int tx_n);
        int n;
        int gap;
        n = (rx_n > tx_n) ? rx_n : tx_n;
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            rx_frame <= (i < rx_n);
            tx_frame <= (i < tx_n);
            @(posedge clk);
            rx_frame <= 1'b0;
            tx_frame <= 1'b0;
            if (i < n - 1) begin
                gap = 1 + $urandom % 3;
                repeat (gap - 1) @(posedge clk);
            end
        end
        @(negedge clk);
    endtask

    task automatic run_step(input step_t s);
        logic [31:0] rd;
        case (s.op)
            op_write: begin
                bus_access(1'b1, s.addr, s.data, rd);
            end
            op_read: begin
                bus_access(1'b0, s.addr, 32'h0, rd);
                check_value("rdata", s.data, rd);
            end
            op_burst: begin
                send_frames(s.rx_n, s.tx_n);
            end
            default: begin
                repeat (s.len) @(negedge clk);
            end
        endcase
        check_value("eir", s.exp_eir, {30'b0, enet_irq_top_i.eir});
        check_value("irq", s.exp_irq, {31'b0, irq});
    endtask

    function automatic void add_step(input op_t op, input logic [enet_irq_pkg::addr_w-1:0] a,
                                     input logic [31:0] d, input int rx_n, input int tx_n,
                                     input int len, input logic [31:0] e_eir,
                                     input logic [31:0] e_irq);
        step_t s;
        s = '{op, a, d, rx_n, tx_n, len, e_eir, e_irq};
        steps.push_back(s);
    endfunction

    // op, addr, data, rx frames, tx frames, wait, eir, irq
    function automatic void load_table();
        add_step(op_read,  enet_irq_pkg::addr_eir,     32'h0, 0, 0, 0, 0, 0);
        add_step(op_read,  enet_irq_pkg::addr_eimr,    32'h0, 0, 0, 0, 0, 0);
        add_step(op_read,  enet_irq_pkg::addr_rx_coal, 32'h0, 0, 0, 0, 0, 0);
        add_step(op_read,  enet_irq_pkg::addr_tx_coal, 32'h0, 0, 0, 0, 0, 0);
        add_step(op_read,  4'h7,                       32'h0, 0, 0, 0, 0, 0);
        // only enable, frame and timer fields stick
        add_step(op_write, enet_irq_pkg::addr_rx_coal, 32'hffff_ffff, 0, 0, 0, 0, 0);
        add_step(op_read,  enet_irq_pkg::addr_rx_coal, 32'h8ff0_ffff, 0, 0, 0, 0, 0);
        add_step(op_write, enet_irq_pkg::addr_tx_coal, 32'h7a5a_1234, 0, 0, 0, 0, 0);
        add_step(op_read,  enet_irq_pkg::addr_tx_coal, 32'h0a50_1234, 0, 0, 0, 0, 0);
        // direct mode, masked then unmasked
        add_step(op_write, enet_irq_pkg::addr_rx_coal, 32'h0, 0, 0, 0, 0, 0);
        add_step(op_burst, 4'h0,                       32'h0, 1, 0, 0, 2, 0);
        add_step(op_write, enet_irq_pkg::addr_eimr,    32'hffff_ffff, 0, 0, 0, 2, 1);
        add_step(op_read,  enet_irq_pkg::addr_eimr,    32'h3, 0, 0, 0, 2, 1);
        add_step(op_write, enet_irq_pkg::addr_eimr,    32'h1, 0, 0, 0, 2, 0);
        // write one to clear
        add_step(op_burst, 4'h0,                       32'h0, 0, 1, 0, 3, 1);
        add_step(op_write, enet_irq_pkg::addr_eir,     32'h0, 0, 0, 0, 3, 1);
        add_step(op_write, enet_irq_pkg::addr_eir,     32'h1, 0, 0, 0, 2, 0);
        add_step(op_burst, 4'h0,                       32'h0, 0, 1, 0, 3, 1);
        add_step(op_write, enet_irq_pkg::addr_eir,     32'h3, 0, 0, 0, 0, 0);
        // frame threshold 4 on rx and 2 on tx, timer threshold out of reach
        add_step(op_write, enet_irq_pkg::addr_rx_coal, 32'h8040_ffff, 0, 0, 0, 0, 0);
        add_step(op_write, enet_irq_pkg::addr_tx_coal, 32'h8020_ffff, 0, 0, 0, 0, 0);
        add_step(op_write, enet_irq_pkg::addr_eimr,    32'h3, 0, 0, 0, 0, 0);
        add_step(op_burst, 4'h0,                       32'h0, 3, 0, 0, 0, 0);
        add_step(op_wait,  4'h0,                       32'h0, 0, 0, 8, 0, 0);
        add_step(op_burst, 4'h0,                       32'h0, 1, 0, 0, 0, 0);
        add_step(op_wait,  4'h0,                       32'h0, 0, 0, 2, 2, 1);
        add_step(op_write, enet_irq_pkg::addr_eir,     32'h2, 0, 0, 0, 0, 0);
        add_step(op_burst, 4'h0,                       32'h0, 0, 1, 0, 0, 0);
        add_step(op_wait,  4'h0,                       32'h0, 0, 0, 4, 0, 0);
        add_step(op_burst, 4'h0,                       32'h0, 4, 1, 0, 1, 1);
        add_step(op_wait,  4'h0,                       32'h0, 0, 0, 2, 3, 1);
        add_step(op_write, enet_irq_pkg::addr_eir,     32'h3, 0, 0, 0, 0, 0);
        // timer threshold 4 units = 128 clocks, frame threshold out of reach
        add_step(op_write, enet_irq_pkg::addr_rx_coal, 32'h8ff0_0004, 0, 0, 0, 0, 0);
        add_step(op_burst, 4'h0,                       32'h0, 1, 0, 0, 0, 0);
        add_step(op_wait,  4'h0,                       32'h0, 0, 0, 126, 0, 0);
        add_step(op_wait,  4'h0,                       32'h0, 0, 0, 6, 2, 1);
        add_step(op_read,  enet_irq_pkg::addr_eir,     32'h2, 0, 0, 0, 2, 1);
        add_step(op_write, enet_irq_pkg::addr_eir,     32'h2, 0, 0, 0, 0, 0);
    endfunction

    initial begin
        void'($urandom(32'h58c5_5148));
        load_table();
        rst_n    <= 1'b0;
        req      <= 1'b0;
        we       <= 1'b0;
        addr     <= '0;
        wdata    <= '0;
        rx_frame <= 1'b0;
        tx_frame <= 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        foreach (steps[i]) begin
            cur_step = i;
            run_step(steps[i]);
        end
        $display("errors: %0d in %0d steps", errors, steps.size());
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // budget: every step gets the longest wait plus room for a handshake or burst
    initial begin
        int max_len;
        int limit;
        max_len = 0;
        @(posedge rst_n);
        foreach (steps[i]) begin
            if (steps[i].len > max_len) begin
                max_len = steps[i].len;
            end
        end
        limit = steps.size() * (max_len + 64) + 100;
        repeat (limit) @(posedge clk);
        $display("timeout: run did not end within %0d cycles, errors: %0d", limit, errors);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule
